// File: tb.f
+incdir+testbench
logic/mc_pkg.sv
logic/request_front.sv
logic/bank_scheduler.sv
logic/dram_datapath.sv
logic/memory_controller.sv
testbench/memory_controller_tb.sv

// File: Makefile
# Verilator build and run of the memory controller testbench

VERILATOR  ?= verilator
TOP        ?= memory_controller_tb
RTL_TOP    ?= memory_controller
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= logic/mc_pkg.sv logic/request_front.sv logic/bank_scheduler.sv \
	logic/dram_datapath.sv logic/memory_controller.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "NO ERRORS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/mc_tb_model.svh
`ifndef MC_TB_MODEL_SVH
`define MC_TB_MODEL_SVH

// reference copy of the storage array with one word per full address
logic [data_w-1:0] ref_mem [2**addr_w];
// data each outstanding read should return in acceptance order
logic [data_w-1:0] exp_reads [$];
logic [31:0]       rng_state = 32'h5d50;
int                errors    = 0;

// xorshift32 advancing one step per call
function automatic logic [31:0] rand_next();
	logic [31:0] x;
	x = rng_state;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	rng_state = x;
	return x;
endfunction

task automatic clear_model();
	for (int a = 0; a < 2**addr_w; a++) begin
		ref_mem[a] = '0;
	end
	exp_reads.delete();
endtask

// called once per request the DUT takes in acceptance order
task automatic model_accept(
	input logic              write,
	input logic [addr_w-1:0] addr,
	input logic [data_w-1:0] data
);
	if (write) begin
		ref_mem[addr] = data;
	end else begin
		exp_reads.push_back(ref_mem[addr]);  // value as of this acceptance
	end
endtask

task automatic check_value(
	input string       name,
	input logic [31:0] expected,
	input logic [31:0] actual
);
	if (actual !== expected) begin
		errors++;
		$display("ERR %s expected %h actual %h", name, expected, actual);
	end
endtask

`endif

// File: testbench/memory_controller_tb.sv
`timescale 1ns/100ps

module memory_controller_tb;
	import mc_pkg::*;

	localparam int n_fill   = 64;
	localparam int n_random = 300;
	localparam int n_burst  = 100;
	localparam int n_stream = 16;
	localparam int n_total  = 2 * n_fill + n_random + n_burst + n_stream + 1;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              in_valid;
	logic              in_request_type;
	logic [addr_w-1:0] in_request_address;
	logic [data_w-1:0] in_request_data;
	logic              out_busy;
	logic              write_done;
	logic              read_done;
	logic [data_w-1:0] data_out;

	string phase_name;
	int    writes_acc  = 0;
	int    reads_acc   = 0;
	int    writes_done = 0;
	int    reads_done  = 0;
	int    busy_cycles = 0;

	`include "mc_tb_model.svh"

	memory_controller DUT (
		.clk               (clk),
		.rst_n             (rst_n),
		.in_valid          (in_valid),
		.in_request_type   (in_request_type),
		.in_request_address(in_request_address),
		.in_request_data   (in_request_data),
		.out_busy          (out_busy),
		.write_done        (write_done),
		.read_done         (read_done),
		.data_out          (data_out)
	);

	always #5 clk = ~clk;

	// 64 word window with bank from sel[5:4], row from sel[3:2] and column from sel[1:0]
	function automatic logic [addr_w-1:0] window_addr(input logic [5:0] sel);
		return {sel[5:4], 6'b0, sel[3:2], 2'b0, sel[1:0]};
	endfunction

	// present one request and hold it until the DUT takes it
	task automatic send(input logic write, input logic [addr_w-1:0] addr,
			input logic [data_w-1:0] data);
		logic taken;
		in_valid           = 1'b1;
		in_request_type    = write;
		in_request_address = addr;
		in_request_data    = data;
		do begin
			taken = !out_busy;  // busy cannot change before the next edge
			@(posedge clk);
			#1;
		end while (!taken);
		in_valid = 1'b0;
	endtask

	// wait for every accepted request to complete
	task automatic drain();
		while (exp_reads.size() != 0 || writes_done != writes_acc) begin
			@(posedge clk);
			#1;
		end
	endtask

	// responses and acceptances sampled mid-cycle where everything is settled
	always @(negedge clk) begin
		if (rst_n) begin
			if (read_done) begin
				reads_done++;
				if (exp_reads.size() == 0) begin
					errors++;
					$display("%s: read_done pulse with no read outstanding", phase_name);
				end else begin
					check_value(phase_name, exp_reads.pop_front(), data_out);
				end
			end
			if (write_done) begin
				writes_done++;
			end
			if (out_busy) begin
				busy_cycles++;
			end
			if (in_valid && !out_busy) begin
				if (in_request_type) begin
					writes_acc++;
				end else begin
					reads_acc++;
				end
				model_accept(in_request_type, in_request_address, in_request_data);
			end
		end
	end

	initial begin
		int limit;
		limit = n_total * (DUT.t_rp + DUT.t_rcd + DUT.cas_latency + 4) + 1000;
		repeat (limit) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles, DUT appears hung", limit);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		logic [31:0] r;
		rst_n              = 1'b0;
		in_valid           = 1'b0;
		in_request_type    = 1'b0;
		in_request_address = '0;
		in_request_data    = '0;
		phase_name         = "reset";
		clear_model();
		repeat (8) begin
			@(posedge clk);
			#1;
			check_value(phase_name, 0, {out_busy, write_done, read_done});
		end
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		check_value(phase_name, 0, {out_busy, write_done, read_done});

		// every word of the window is written before anything reads it
		phase_name = "fill_readback";
		for (int i = 0; i < n_fill; i++) begin
			send(1'b1, window_addr(i[5:0]), data_w'(i));
		end
		for (int i = 0; i < n_fill; i++) begin
			send(1'b0, window_addr(i[5:0]), '0);
		end
		drain();

		phase_name = "random_mix";
		for (int i = 0; i < n_random; i++) begin
			r = rand_next();
			send(r[0], window_addr(r[6:1]), r[31:16]);
			if (r[8:7] == 2'b00) begin
				@(posedge clk);  // idle cycle now and then
				#1;
			end
		end
		drain();

		// back to back requests to four rows of one bank pile up conflicts and fill the queue
		phase_name  = "back_pressure";
		busy_cycles = 0;
		for (int i = 0; i < n_burst; i++) begin
			r = rand_next();
			send(r[0], window_addr({2'b01, r[4:1]}), r[31:16]);
		end
		drain();
		if (busy_cycles == 0) begin
			errors++;
			$display("out_busy never rose while requests came every cycle");
		end

		phase_name = "read_stream";
		send(1'b0, window_addr(6'b100100), '0);  // opens bank 2 row 1
		for (int i = 0; i < n_stream; i++) begin
			send(1'b0, window_addr({4'b1001, i[1:0]}), '0);
		end
		drain();

		repeat (5) @(posedge clk);  // catch any stray pulses
		#1;
		check_value("write_count", writes_acc, writes_done);
		check_value("read_count", reads_acc, reads_done);
		$display("summary: %0d errors, %0d writes and %0d reads completed",
			errors, writes_done, reads_done);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: logic/memory_controller.sv
`timescale 1ns/100ps

module memory_controller #(
	parameter int queue_depth = 4,
	parameter int t_rcd       = 3,
	parameter int t_rp        = 3,
	parameter int cas_latency = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      in_valid,
	input  logic                      in_request_type,
	input  logic [mc_pkg::addr_w-1:0] in_request_address,
	input  logic [mc_pkg::data_w-1:0] in_request_data,
	output logic                      out_busy,
	output logic                      write_done,
	output logic                      read_done,
	output logic [mc_pkg::data_w-1:0] data_out
);
	import mc_pkg::*;

	mc_dec_req_t dec_req;    // queue head
	logic        req_valid;
	logic        req_take;
	mc_cmd_t     cmd;

	// client side queue and address split
	request_front #(
		.queue_depth(queue_depth)
	) u_front (
		.clk               (clk),
		.rst_n             (rst_n),
		.in_valid          (in_valid),
		.in_request_type   (in_request_type),
		.in_request_address(in_request_address),
		.in_request_data   (in_request_data),
		.out_busy          (out_busy),
		.req               (dec_req),
		.req_valid         (req_valid),
		.req_take          (req_take)
	);

	bank_scheduler #(
		.t_rcd(t_rcd),
		.t_rp (t_rp)
	) u_sched (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (dec_req),
		.req_valid(req_valid),
		.req_take (req_take),
		.cmd      (cmd)
	);

	// storage and completions
	dram_datapath #(
		.cas_latency(cas_latency)
	) u_datapath (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.write_done(write_done),
		.read_done (read_done),
		.data_out  (data_out)
	);

endmodule

// File: logic/dram_datapath.sv
`timescale 1ns/100ps

module dram_datapath #(
	parameter int cas_latency = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mc_pkg::mc_cmd_t           cmd,
	output logic                      write_done,
	output logic                      read_done,
	output logic [mc_pkg::data_w-1:0] data_out
);
	import mc_pkg::*;

	localparam int depth = 2 ** addr_w;

	logic [data_w-1:0]      mem [depth];
	logic [addr_w-1:0]      cmd_addr;
	logic                   is_wr;
	logic                   is_rd;
	logic [cas_latency-1:0] rd_valid_q;               // one bit per read in flight
	logic [data_w-1:0]      rd_data_q [cas_latency];

	// storage is indexed the same way the address was split
	assign cmd_addr = {cmd.bank, cmd.row, cmd.col};

	// ACT and PRE only matter for timing and do nothing here
	assign is_wr = (cmd.op == WR);
	assign is_rd = (cmd.op == RD);

	always_ff @(posedge clk) begin
		if (is_wr) begin
			mem[cmd_addr] <= cmd.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			write_done <= 1'b0;
			rd_valid_q <= '0;
		end else begin
			write_done    <= is_wr;  // same edge the array takes the word
			rd_valid_q[0] <= is_rd;
			for (int i = 1; i < cas_latency; i++) begin
				rd_valid_q[i] <= rd_valid_q[i-1];
			end
		end
	end

	// data moves every cycle alongside its valid bit
	always_ff @(posedge clk) begin
		rd_data_q[0] <= mem[cmd_addr];
		for (int i = 1; i < cas_latency; i++) begin
			rd_data_q[i] <= rd_data_q[i-1];
		end
	end

	// last stage is cas_latency cycles after the RD
	assign read_done = rd_valid_q[cas_latency-1];
	assign data_out  = rd_data_q[cas_latency-1];

endmodule

// File: logic/bank_scheduler.sv
`timescale 1ns/100ps

module bank_scheduler #(
	parameter int t_rcd = 3,
	parameter int t_rp  = 3
) (
	input  logic                clk,
	input  logic                rst_n,
	input  mc_pkg::mc_dec_req_t req,
	input  logic                req_valid,
	output logic                req_take,
	output mc_pkg::mc_cmd_t     cmd
);
	import mc_pkg::*;

	localparam int n_banks = 2 ** bank_w;
	localparam int gap_max = (t_rcd > t_rp) ? t_rcd : t_rp;
	localparam int gap_w   = $clog2(gap_max + 1);

	// how the head request relates to its bank
	typedef enum logic [1:0] {
		ROW_HIT,
		ROW_CLOSED,
		ROW_CONFLICT
	} access_e;

	logic [n_banks-1:0] bank_open_q;
	logic [row_w-1:0]   open_row_q [n_banks];
	logic [gap_w-1:0]   gap_q;       // cycles left before the next command may go out
	access_e            access;
	logic               head_ready;

	always_comb begin
		if (!bank_open_q[req.bank]) begin
			access = ROW_CLOSED;
		end else if (open_row_q[req.bank] != req.row) begin
			access = ROW_CONFLICT;
		end else begin
			access = ROW_HIT;
		end
	end

	assign head_ready = req_valid && (gap_q == '0);

	// one command per cycle decided from the queue head and the bank state
	//
	// a hit goes straight to RD/WR, a closed bank needs ACT first and a
	// conflict needs PRE then ACT, each followed by its timing gap
	always_comb begin
		cmd      = '0;
		cmd.op   = NOP;
		req_take = 1'b0;
		if (head_ready) begin
			cmd.bank  = req.bank;
			cmd.row   = req.row;
			cmd.col   = req.col;
			cmd.wdata = req.data;
			case (access)
				ROW_CLOSED: begin
					cmd.op = ACT;
				end
				ROW_CONFLICT: begin
					cmd.op = PRE;  // close the wrong row first
				end
				default: begin
					if (req.write) begin
						cmd.op = WR;
					end else begin
						cmd.op = RD;
					end
					req_take = 1'b1;  // head leaves with its data command
				end
			endcase
		end
	end

	// bank flags and the shared gap counter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bank_open_q <= '0;
			gap_q       <= '0;
		end else begin
			case (cmd.op)
				ACT: begin
					bank_open_q[cmd.bank] <= 1'b1;
					gap_q                 <= gap_w'(t_rcd - 1);  // RD/WR lands t_rcd later
				end
				PRE: begin
					bank_open_q[cmd.bank] <= 1'b0;
					gap_q                 <= gap_w'(t_rp - 1);
				end
				default: begin
					if (gap_q != '0) begin
						gap_q <= gap_q - 1'b1;
					end
				end
			endcase
		end
	end

	// remembers which row each ACT opened
	always_ff @(posedge clk) begin
		if (cmd.op == ACT) begin
			open_row_q[cmd.bank] <= cmd.row;
		end
	end

endmodule

// File: logic/request_front.sv
`timescale 1ns/100ps

module request_front #(
	parameter int queue_depth = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      in_valid,
	input  logic                      in_request_type,
	input  logic [mc_pkg::addr_w-1:0] in_request_address,
	input  logic [mc_pkg::data_w-1:0] in_request_data,
	output logic                      out_busy,
	output mc_pkg::mc_dec_req_t       req,
	output logic                      req_valid,
	input  logic                      req_take
);
	import mc_pkg::*;

	localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w = $clog2(queue_depth + 1);

	mc_dec_req_t      queue_q [queue_depth];
	logic [ptr_w-1:0] wr_ptr_q;
	logic [ptr_w-1:0] rd_ptr_q;
	logic [cnt_w-1:0] count_q;
	logic [cnt_w-1:0] count_d;
	mc_req_t          in_req;
	logic             push;
	logic             pop;

	// bank in the top address bits, column in the lowest ones
	function automatic mc_dec_req_t decode(input mc_req_t r);
		mc_dec_req_t d;
		d.write = r.write;
		d.bank  = r.addr[addr_w-1 -: bank_w];
		d.row   = r.addr[col_w +: row_w];
		d.col   = r.addr[col_w-1:0];
		d.data  = r.data;
		return d;
	endfunction

	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(queue_depth - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign in_req = '{write: in_request_type, addr: in_request_address, data: in_request_data};

	assign push = in_valid && !out_busy;  // client sees busy as its only flow control
	assign pop  = req_take && req_valid;

	// push and pop together leave the fill level alone
	always_comb begin
		count_d = count_q;
		if (push && !pop) begin
			count_d = count_q + 1'b1;
		end else if (pop && !push) begin
			count_d = count_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			out_busy <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			count_q  <= count_d;
			out_busy <= (count_d == cnt_w'(queue_depth));  // full next cycle
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			queue_q[wr_ptr_q] <= decode(in_req);
		end
	end

	assign req       = queue_q[rd_ptr_q];
	assign req_valid = (count_q != '0);

endmodule

// File: logic/mc_pkg.sv
package mc_pkg;

	// field widths of the split address
	localparam int data_w = 16;
	localparam int bank_w = 2;
	localparam int row_w  = 8;
	localparam int col_w  = 4;
	localparam int addr_w = bank_w + row_w + col_w;  // bank | row | col

	// request as the client hands it over
	typedef struct packed {
		logic              write;  // 1 means write
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
	} mc_req_t;

	// same request with the address already split
	typedef struct packed {
		logic              write;
		logic [bank_w-1:0] bank;
		logic [row_w-1:0]  row;
		logic [col_w-1:0]  col;
		logic [data_w-1:0] data;
	} mc_dec_req_t;

	typedef enum logic [2:0] {
		NOP = 3'd0,
		ACT = 3'd1,
		RD  = 3'd2,
		WR  = 3'd3,
		PRE = 3'd4
	} mc_cmd_e;

	// one command toward the storage side with NOP when idle
	typedef struct packed {
		mc_cmd_e           op;
		logic [bank_w-1:0] bank;
		logic [row_w-1:0]  row;
		logic [col_w-1:0]  col;
		logic [data_w-1:0] wdata;  // only meaningful with WR
	} mc_cmd_t;

endpackage
